/* Makefile */
# Verilator build for the trellis register core testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tbTrellisTop
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "Run ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/trellis_defines.svh */
// Trellis demodulator register core
// Bus and sample widths, register map, version and reset stretch length
`ifndef TRELLIS_DEFINES_SVH
`define TRELLIS_DEFINES_SVH

// Processor bus
`define ADDR_W          12
`define DATA_W          16

// Sample and DAC widths
`define SAMPLE_W        18
`define DACOUT_W        14        // Upper bits of a sample
`define NUM_DACS        3

// Version register contents
`define VER_NUMBER      16'h0076

// Cycles that the soft reset stays high
`define RESET_STRETCH   5

// Address space codes, compared against address bits 11:8
`define SPACE_MISC      4'h0
`define SPACE_DAC       4'h1

// Free-running clock counter
`define CLOCK_CNT_W     32

`endif

/* sim.f */
+incdir+include
source/trellisPkg.sv
source/busControl.sv
source/miscRegs.sv
source/dacChannel.sv
source/trellisTop.sv
testbench/tbClockGen.sv
testbench/trellisTop_assert.sv
testbench/tbTrellisTop.sv

/* source/busControl.sv */
// Wishbone classic slave for the trellis register core
// Decodes the address into the misc and DAC spaces, strobes the selected
// block for one cycle and returns a registered read word with the ack
`timescale 1ns/1ps
`include "trellis_defines.svh"

module busControl
  import trellisPkg::*;
(
  input  logic                 ck933,
  input  logic                 clockCounterEn,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  logic [`ADDR_W-1:0]   adr_i,
  input  logic [`DATA_W-1:0]   dat_i,
  output logic [`DATA_W-1:0]   dat_o,
  output logic                 ack_o,
  output logic                 regWrite_o,
  output logic                 readStrobe_o,
  output miscReg_t             regAddr_o,
  output logic [`DATA_W-1:0]   regWdata_o,
  output logic                 miscSel_o,
  output logic [`NUM_DACS-1:0] dacSel_o,
  input  logic [`DATA_W-1:0]   miscRdata_i,
  input  logic [`DATA_W-1:0]   dacRdata_i [`NUM_DACS]
);

  busState_t          busState;
  regSpace_t          space;
  logic [1:0]         dacIdx;
  logic               busActive;
  logic [`DATA_W-1:0] rdMux;

  //**************************************************
  // Address decode
  //**************************************************
  assign dacIdx = adr_i[2:1];  // Channel number in DAC space

  always_comb begin
    if (adr_i[`ADDR_W-1:8] == `SPACE_MISC) begin
      space = SPACE_MISC;
    end else if (adr_i[`ADDR_W-1:8] == `SPACE_DAC && adr_i[7:3] == '0 &&
                 dacIdx < `NUM_DACS) begin
      space = SPACE_DAC;
    end else begin
      space = SPACE_NONE;  // Acked, reads zero
    end
  end

  // Request accepted last edge and master still holding it
  assign busActive = (busState == BUS_ACK) && cyc_i && stb_i;

  assign regWrite_o   = busActive && we_i;
  assign readStrobe_o = busActive && !we_i;
  assign regAddr_o    = miscReg_t'(adr_i[7:0]);
  assign regWdata_o   = dat_i;
  assign miscSel_o    = busActive && (space == SPACE_MISC);

  always_comb begin
    for (int i = 0; i < `NUM_DACS; i++) begin
      dacSel_o[i] = busActive && (space == SPACE_DAC) && (dacIdx == 2'(i));
    end
  end

  // Read word from the addressed block
  always_comb begin
    case (space)
      SPACE_MISC: rdMux = miscRdata_i;
      SPACE_DAC:  rdMux = dacRdata_i[dacIdx];
      default:    rdMux = '0;
    endcase
  end

  //**************************************************
  // Handshake FSM
  //**************************************************
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      busState <= BUS_IDLE;
      ack_o    <= 1'b0;
      dat_o    <= '0;
    end else begin
      if (busState == BUS_IDLE) begin
        // Ignore the request that is still up during its own ack
        if (cyc_i && stb_i && !ack_o) busState <= BUS_ACK;
      end else begin
        busState <= BUS_IDLE;
      end
      ack_o <= busActive;
      dat_o <= (busActive && !we_i) ? rdMux : '0;
    end
  end

endmodule

/* source/dacChannel.sv */
// One DAC output channel
// Source select register, registered demod/trellis sample mux and an
// offset-binary output register loaded on the sample sync
`timescale 1ns/1ps
`include "trellis_defines.svh"

module dacChannel
  import trellisPkg::*;
#(
  parameter int CHANNEL = 0  // Matches address bits 2:1
) (
  input  logic                 ck933,
  input  logic                 clockCounterEn,
  input  logic                 softReset_i,
  input  logic [`NUM_DACS-1:0] dacSel_i,
  input  logic                 regWrite_i,
  input  logic [`DATA_W-1:0]   regWdata_i,
  output logic [`DATA_W-1:0]   dacRdata_o,
  input  sample_t              demodData_i,
  input  logic                 demodSync_i,
  input  sample_t              trellisData_i,
  input  logic                 trellisSync_i,
  output logic [`DACOUT_W-1:0] dacData_o
);

  dacSource_t srcSel;
  sample_t    demodReg;
  sample_t    trellisReg;
  sample_t    muxData;
  logic       demodSyncReg;
  logic       trellisSyncReg;
  logic       muxSync;
  logic       useTrellis;

  // Source select register
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      srcSel <= DAC_DEMOD;
    end else if (softReset_i) begin
      srcSel <= DAC_DEMOD;
    end else if (dacSel_i[CHANNEL] && regWrite_i) begin
      srcSel <= dacSource_t'(regWdata_i[2:0]);
    end
  end

  assign dacRdata_o = {{(`DATA_W-3){1'b0}}, srcSel};
  assign useTrellis = srcSel inside {DAC_TRELLIS_I, DAC_TRELLIS_Q,
                                     DAC_TRELLIS_PHERR, DAC_TRELLIS_INDEX};

  // Reclock samples, then mux
  always_ff @(posedge ck933) begin
    demodReg   <= demodData_i;
    trellisReg <= trellisData_i;
    muxData    <= useTrellis ? trellisReg : demodReg;
  end

  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      demodSyncReg   <= 1'b0;
      trellisSyncReg <= 1'b0;
      muxSync        <= 1'b0;
      dacData_o      <= '0;
    end else if (softReset_i) begin
      demodSyncReg   <= 1'b0;
      trellisSyncReg <= 1'b0;
      muxSync        <= 1'b0;
      dacData_o      <= '0;
    end else begin
      demodSyncReg   <= demodSync_i;
      trellisSyncReg <= trellisSync_i;
      muxSync        <= useTrellis ? trellisSyncReg : demodSyncReg;
      // Offset binary, top bits only
      if (muxSync) begin
        dacData_o <= {~muxData[`SAMPLE_W-1], muxData[`SAMPLE_W-2:`SAMPLE_W-`DACOUT_W]};
      end
    end
  end

endmodule

/* source/miscRegs.sv */
// Miscellaneous register space
// Version constant, free-running clock counter with a captured hold,
// and the soft reset request stretched over a fixed number of cycles
`timescale 1ns/1ps
`include "trellis_defines.svh"

module miscRegs
  import trellisPkg::*;
(
  input  logic               ck933,
  input  logic               clockCounterEn,
  input  logic               miscSel_i,
  input  logic               regWrite_i,
  input  logic               readStrobe_i,
  input  miscReg_t           regAddr_i,
  output logic [`DATA_W-1:0] miscRdata_o,
  output logic               softReset_o
);

  localparam int STRETCH_W = $clog2(`RESET_STRETCH + 1);

  logic [`CLOCK_CNT_W-1:0]         clockCounter;
  logic [`CLOCK_CNT_W-`DATA_W-1:0] clockHoldHi;  // Upper half only is read back
  logic [STRETCH_W-1:0]            resetCount;
  logic                            resetWrite;
  logic                            clockWrite;
  logic                            clockCapture;

  assign resetWrite   = miscSel_i && regWrite_i && (regAddr_i == MISC_RESET);
  assign clockWrite   = miscSel_i && regWrite_i &&
                        (regAddr_i inside {MISC_CLOCK_LO, MISC_CLOCK_HI});
  assign clockCapture = miscSel_i && readStrobe_i && (regAddr_i == MISC_CLOCK_LO);

  //**************************************************
  // Clock counter
  //**************************************************
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      clockCounter <= '0;
      clockHoldHi  <= '0;
    end else begin
      if (clockWrite) begin
        clockCounter <= '0;  // Restart timing
      end else begin
        clockCounter <= clockCounter + 1'b1;
      end
      // Low half read freezes the high half for the next read
      if (clockCapture) clockHoldHi <= clockCounter[`CLOCK_CNT_W-1:`DATA_W];
    end
  end

  //**************************************************
  // Soft reset stretcher
  //**************************************************
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      resetCount  <= '0;
      softReset_o <= 1'b0;
    end else begin
      softReset_o <= (resetCount != '0);  // One cycle behind the count
      if (resetWrite) begin
        resetCount <= STRETCH_W'(`RESET_STRETCH);
      end else if (resetCount != '0) begin
        resetCount <= resetCount - 1'b1;
      end
    end
  end

  // Read decode
  always_comb begin
    case (regAddr_i)
      MISC_VERSION:  miscRdata_o = `VER_NUMBER;
      MISC_CLOCK_LO: miscRdata_o = clockCounter[`DATA_W-1:0];  // Live value
      MISC_CLOCK_HI: miscRdata_o = clockHoldHi;
      default:       miscRdata_o = '0;
    endcase
  end

endmodule

/* source/trellisPkg.sv */
// Trellis core types
// Address spaces, misc register offsets, DAC source opcodes, bus FSM states
// and the demod/trellis sample type
`include "trellis_defines.svh"

package trellisPkg;

  typedef enum logic [1:0] {
    SPACE_MISC = 2'd0,
    SPACE_DAC  = 2'd1,
    SPACE_NONE = 2'd2
  } regSpace_t;

  // Word offsets inside the misc space
  typedef enum logic [7:0] {
    MISC_RESET    = 8'h00,
    MISC_VERSION  = 8'h02,
    MISC_CLOCK_LO = 8'h04,
    MISC_CLOCK_HI = 8'h06
  } miscReg_t;

  typedef enum logic [2:0] {
    DAC_DEMOD         = 3'd0,
    DAC_TRELLIS_I     = 3'd1,
    DAC_TRELLIS_Q     = 3'd2,
    DAC_TRELLIS_PHERR = 3'd3,
    DAC_TRELLIS_INDEX = 3'd4
  } dacSource_t;

  typedef enum logic {BUS_IDLE, BUS_ACK} busState_t;

  typedef logic signed [`SAMPLE_W-1:0] sample_t;

endpackage

/* source/trellisTop.sv */
// Trellis demodulator top level, processor side
// Wishbone register decode, misc registers and three DAC output channels
`timescale 1ns/1ps
`include "trellis_defines.svh"

module trellisTop
  import trellisPkg::*;
(
  input  logic                 ck933,
  input  logic                 clockCounterEn,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  logic [`ADDR_W-1:0]   adr_i,
  input  logic [`DATA_W-1:0]   dat_i,
  output logic [`DATA_W-1:0]   dat_o,
  output logic                 ack_o,
  input  sample_t              demodData_i [`NUM_DACS],
  input  logic [`NUM_DACS-1:0] demodSync_i,
  input  sample_t              trellisData_i [`NUM_DACS],
  input  logic [`NUM_DACS-1:0] trellisSync_i,
  output logic [`DACOUT_W-1:0] dacData_o [`NUM_DACS],
  output logic                 dacRst_o
);

  logic                 regWrite;
  logic                 readStrobe;
  miscReg_t             regAddr;
  logic [`DATA_W-1:0]   regWdata;
  logic                 miscSel;
  logic [`NUM_DACS-1:0] dacSel;
  logic [`DATA_W-1:0]   miscRdata;
  logic [`DATA_W-1:0]   dacRdata [`NUM_DACS];
  logic                 softReset;

  //**************************************************
  // Register bus
  //**************************************************
  busControl busControl_i (
    .ck933        (ck933),
    .clockCounterEn(clockCounterEn),
    .cyc_i        (cyc_i),
    .stb_i        (stb_i),
    .we_i         (we_i),
    .adr_i        (adr_i),
    .dat_i        (dat_i),
    .dat_o        (dat_o),
    .ack_o        (ack_o),
    .regWrite_o   (regWrite),
    .readStrobe_o (readStrobe),
    .regAddr_o    (regAddr),
    .regWdata_o   (regWdata),
    .miscSel_o    (miscSel),
    .dacSel_o     (dacSel),
    .miscRdata_i  (miscRdata),
    .dacRdata_i   (dacRdata)
  );

  miscRegs miscRegs_i (
    .ck933         (ck933),
    .clockCounterEn(clockCounterEn),
    .miscSel_i     (miscSel),
    .regWrite_i    (regWrite),
    .readStrobe_i  (readStrobe),
    .regAddr_i     (regAddr),
    .miscRdata_o   (miscRdata),
    .softReset_o   (softReset)
  );

  assign dacRst_o = softReset;  // Stretched reset also leaves on the DAC pin

  //**************************************************
  // DAC outputs
  //**************************************************
  for (genvar gi = 0; gi < `NUM_DACS; gi++) begin : genDac
    dacChannel #(.CHANNEL(gi)) dacChannel_i (
      .ck933         (ck933),
      .clockCounterEn(clockCounterEn),
      .softReset_i   (softReset),
      .dacSel_i      (dacSel),
      .regWrite_i    (regWrite),
      .regWdata_i    (regWdata),
      .dacRdata_o    (dacRdata[gi]),
      .demodData_i   (demodData_i[gi]),
      .demodSync_i   (demodSync_i[gi]),
      .trellisData_i (trellisData_i[gi]),
      .trellisSync_i (trellisSync_i[gi]),
      .dacData_o     (dacData_o[gi])
    );
  end

endmodule

/* testbench/tbClockGen.sv */
// Clock and reset source for the trellis core testbench
// 4 ns clock, reset held high for the first three cycles
`timescale 1ns/1ps

module tbClockGen (
  output logic ck933,
  output logic clockCounterEn
);

  initial begin
    ck933 = 1'b0;
    forever #2 ck933 = ~ck933;
  end

  initial begin
    clockCounterEn = 1'b1;
    repeat (3) @(posedge ck933);
    @(negedge ck933);  // Release away from the active edge
    clockCounterEn = 1'b0;
  end

endmodule

/* testbench/tbTrellisTop.sv */
// Testbench for the trellis register core
// Table of bus accesses, random samples through the DAC channels,
// clock counter and soft reset checks
`timescale 1ns/1ps
`include "trellis_defines.svh"

module tbTrellisTop
  import trellisPkg::*;
();

  typedef enum logic {OP_WRITE, OP_READ} busOp_t;

  typedef struct {
    busOp_t             op;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] wdata;
    logic [`DATA_W-1:0] expRd;
  } busStep_t;

  logic                 ck933;
  logic                 clockCounterEn;
  logic                 busCyc;
  logic                 busStb;
  logic                 busWe;
  logic [`ADDR_W-1:0]   busAdr;
  logic [`DATA_W-1:0]   busDatW;
  logic [`DATA_W-1:0]   busDatR;
  logic                 busAck;
  sample_t              demodData [`NUM_DACS];
  logic [`NUM_DACS-1:0] demodSync;
  sample_t              trellisData [`NUM_DACS];
  logic [`NUM_DACS-1:0] trellisSync;
  logic [`DACOUT_W-1:0] dacData [`NUM_DACS];
  logic                 dacRst;

  busStep_t    steps [$];
  logic [31:0] lfsr;
  int          errors = 0;
  int          checks = 0;

  tbClockGen tbClockGen_i (
    .ck933         (ck933),
    .clockCounterEn(clockCounterEn)
  );

  trellisTop trellisTop_i (
    .ck933         (ck933),
    .clockCounterEn(clockCounterEn),
    .cyc_i         (busCyc),
    .stb_i         (busStb),
    .we_i          (busWe),
    .adr_i         (busAdr),
    .dat_i         (busDatW),
    .dat_o         (busDatR),
    .ack_o         (busAck),
    .demodData_i   (demodData),
    .demodSync_i   (demodSync),
    .trellisData_i (trellisData),
    .trellisSync_i (trellisSync),
    .dacData_o     (dacData),
    .dacRst_o      (dacRst)
  );

  //**************************************************
  // Helpers
  //**************************************************
  task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s, got 0x%0h expected 0x%0h", $time, msg, got, exp);
    end
  endtask

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  task automatic randomBits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr[0]};  // One step per bit
      lfsr  = lfsrNext(lfsr);
    end
  endtask

  function automatic logic [`ADDR_W-1:0] dacAddr(input int ch);
    return 12'h100 + 12'(2 * ch);
  endfunction

  // Offset binary of the top 14 bits: two's complement plus half scale
  function automatic logic [`DACOUT_W-1:0] offsetTop(input sample_t s);
    logic [`DACOUT_W-1:0] topBits;
    topBits = s[`SAMPLE_W-1:`SAMPLE_W-`DACOUT_W];
    return topBits + {1'b1, {(`DACOUT_W-1){1'b0}}};
  endfunction

  // Called on a falling edge, returns on a falling edge
  task automatic busAccess(input busOp_t op, input logic [`ADDR_W-1:0] addr,
                           input logic [`DATA_W-1:0] wdata, output logic [`DATA_W-1:0] rdata);
    int waitCycles;
    waitCycles = 0;
    busCyc  = 1'b1;
    busStb  = 1'b1;
    busWe   = (op == OP_WRITE);
    busAdr  = addr;
    busDatW = wdata;
    do begin
      @(negedge ck933);
      waitCycles++;
    end while (!busAck && waitCycles < 16);
    if (!busAck) begin
      errors++;
      $display("ERROR: no acknowledge for bus access to address 0x%03h", addr);
    end
    rdata = busDatR;
    @(negedge ck933);  // Hold through the edge that sees ack
    busCyc = 1'b0;
    busStb = 1'b0;
    busWe  = 1'b0;
  endtask

  task automatic busWrite(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] wdata);
    logic [`DATA_W-1:0] unused;
    busAccess(OP_WRITE, addr, wdata, unused);
  endtask

  task automatic busRead(input logic [`ADDR_W-1:0] addr, output logic [`DATA_W-1:0] rdata);
    busAccess(OP_READ, addr, '0, rdata);
  endtask

  function automatic void addStep(busOp_t op, logic [`ADDR_W-1:0] addr,
                                  logic [`DATA_W-1:0] wdata, logic [`DATA_W-1:0] expRd);
    busStep_t s;
    s.op    = op;
    s.addr  = addr;
    s.wdata = wdata;
    s.expRd = expRd;
    steps.push_back(s);
  endfunction

  //**************************************************
  // Bus table
  //**************************************************
  function automatic void buildTable();
    logic [2:0] selModel [`NUM_DACS];
    addStep(OP_READ, 12'h002, 16'h0, `VER_NUMBER);
    addStep(OP_READ, 12'h008, 16'h0, 16'h0);     // Unused misc offset
    addStep(OP_READ, 12'h106, 16'h0, 16'h0);     // No fourth DAC
    addStep(OP_READ, 12'h110, 16'h0, 16'h0);
    addStep(OP_READ, 12'h200, 16'h0, 16'h0);
    addStep(OP_WRITE, 12'h300, 16'hbeef, 16'h0);
    addStep(OP_READ, 12'hf02, 16'h0, 16'h0);
    for (int ch = 0; ch < `NUM_DACS; ch++) begin
      selModel[ch] = 3'(DAC_DEMOD);
      addStep(OP_READ, dacAddr(ch), 16'h0, 16'h0);
    end
    // Each code on each channel, junk in the upper data bits
    for (int ch = 0; ch < `NUM_DACS; ch++) begin
      for (int code = 0; code <= 4; code++) begin
        selModel[ch] = 3'(code);
        addStep(OP_WRITE, dacAddr(ch), {13'h1b6d, 3'(code)}, 16'h0);
        for (int rd = 0; rd < `NUM_DACS; rd++) begin
          addStep(OP_READ, dacAddr(rd), 16'h0, {13'h0, selModel[rd]});
        end
      end
    end
  endfunction

  //**************************************************
  // Directed tests
  //**************************************************
  task automatic dacPathTest(input dacSource_t src);
    logic [31:0]          rnd;
    logic [`DACOUT_W-1:0] expOut [`NUM_DACS];
    for (int ch = 0; ch < `NUM_DACS; ch++) busWrite(dacAddr(ch), 16'(src));
    for (int n = 0; n < 8; n++) begin
      for (int ch = 0; ch < `NUM_DACS; ch++) begin
        randomBits(`SAMPLE_W, rnd);
        demodData[ch] = rnd[`SAMPLE_W-1:0];
        randomBits(`SAMPLE_W, rnd);
        trellisData[ch] = rnd[`SAMPLE_W-1:0];
        expOut[ch] = offsetTop((src == DAC_DEMOD) ? demodData[ch] : trellisData[ch]);
      end
      // Only the selected source's sync
      if (src == DAC_DEMOD) begin
        demodSync = '1;
      end else begin
        trellisSync = '1;
      end
      @(negedge ck933);
      demodSync   = '0;
      trellisSync = '0;
      repeat (2) @(negedge ck933);  // Two edges of latency
      for (int ch = 0; ch < `NUM_DACS; ch++) begin
        checkValue(32'(dacData[ch]), 32'(expOut[ch]), $sformatf("DAC %0d sample %0d", ch, n));
        randomBits(`SAMPLE_W, rnd);
        demodData[ch] = rnd[`SAMPLE_W-1:0];
        randomBits(`SAMPLE_W, rnd);
        trellisData[ch] = rnd[`SAMPLE_W-1:0];
      end
      // Sync of the unselected source must not load the new samples
      if (src == DAC_DEMOD) begin
        trellisSync = '1;
      end else begin
        demodSync = '1;
      end
      @(negedge ck933);
      demodSync   = '0;
      trellisSync = '0;
      repeat (2) @(negedge ck933);
      for (int ch = 0; ch < `NUM_DACS; ch++) begin
        checkValue(32'(dacData[ch]), 32'(expOut[ch]), $sformatf("DAC %0d hold %0d", ch, n));
      end
    end
  endtask

  task automatic clockTest();
    logic [`DATA_W-1:0] firstLo;
    logic [`DATA_W-1:0] secondLo;
    logic [`DATA_W-1:0] hiWord;
    busWrite(12'h004, 16'h0);
    busRead(12'h004, firstLo);
    busRead(12'h004, secondLo);
    busRead(12'h006, hiWord);
    checkValue(32'(firstLo < 16'd64), 32'd1, "clock low word after clear below 64");
    checkValue(32'(secondLo > firstLo), 32'd1, "clock low word increases");
    checkValue(32'(hiWord), 32'd0, "clock high word from hold");
  endtask

  task automatic softResetTest();
    int                 waitCycles;
    int                 highCycles;
    logic [`DATA_W-1:0] rdata;
    busWrite(12'h000, 16'h0001);
    waitCycles = 0;
    while (!dacRst && waitCycles < 8) begin
      @(negedge ck933);
      waitCycles++;
    end
    if (!dacRst) begin
      errors++;
      $display("ERROR: dacRst_o did not rise after the soft reset write");
    end
    highCycles = 0;
    while (dacRst && highCycles < 20) begin
      highCycles++;
      @(negedge ck933);
    end
    checkValue(32'(highCycles), 32'(`RESET_STRETCH), "dacRst_o pulse length in cycles");
    for (int ch = 0; ch < `NUM_DACS; ch++) begin
      busRead(dacAddr(ch), rdata);
      checkValue(32'(rdata), 32'(DAC_DEMOD), $sformatf("select %0d after soft reset", ch));
      checkValue(32'(dacData[ch]), 32'd0, $sformatf("DAC %0d output after soft reset", ch));
    end
  endtask

  //**************************************************
  // Main sequence and watchdog
  //**************************************************
  initial begin : main
    logic [`DATA_W-1:0] rdata;
    int                 totalErrors;
    busCyc      = 1'b0;
    busStb      = 1'b0;
    busWe       = 1'b0;
    busAdr      = '0;
    busDatW     = '0;
    demodSync   = '0;
    trellisSync = '0;
    for (int ch = 0; ch < `NUM_DACS; ch++) begin
      demodData[ch]   = '0;
      trellisData[ch] = '0;
    end
    lfsr = 32'hdac28824;
    buildTable();
    wait (!clockCounterEn);
    @(negedge ck933);

    checkValue(32'(busAck), 32'd0, "ack_o after reset");
    checkValue(32'(busDatR), 32'd0, "dat_o after reset");
    checkValue(32'(dacRst), 32'd0, "dacRst_o after reset");
    for (int ch = 0; ch < `NUM_DACS; ch++) begin
      checkValue(32'(dacData[ch]), 32'd0, $sformatf("DAC %0d output after reset", ch));
    end

    foreach (steps[i]) begin
      busAccess(steps[i].op, steps[i].addr, steps[i].wdata, rdata);
      if (steps[i].op == OP_READ) begin
        checkValue(32'(rdata), 32'(steps[i].expRd),
                   $sformatf("step %0d read of 0x%03h", i, steps[i].addr));
      end
    end

    dacPathTest(DAC_DEMOD);
    dacPathTest(DAC_TRELLIS_PHERR);
    clockTest();
    softResetTest();

    totalErrors = errors + trellisTop_i.trellisTop_assert_i.failCount;
    $display("Checks: %0d, check errors: %0d, assertion failures: %0d",
             checks, errors, trellisTop_i.trellisTop_assert_i.failCount);
    if (totalErrors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    #1;  // Table is built by now
    limit = steps.size() * 20 + 500;
    repeat (limit) @(posedge ck933);
    $display("ERROR: watchdog expired after %0d cycles", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* testbench/trellisTop_assert.sv */
// Protocol checks bound to the trellis core top level
// Wishbone ack rules and the length of the stretched DAC reset
`timescale 1ns/1ps
`include "trellis_defines.svh"

module trellisTop_assert (
  input logic ck933,
  input logic clockCounterEn,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_o,
  input logic dacRst_o
);

  int failCount = 0;  // Summed into the testbench error total
  int rstHighCycles;

  // Length of the current dacRst_o pulse
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      rstHighCycles <= 0;
    end else if (dacRst_o) begin
      rstHighCycles <= rstHighCycles + 1;
    end else begin
      rstHighCycles <= 0;
    end
  end

  ackInRequest: assert property (@(posedge ck933) disable iff (clockCounterEn)
    ack_o |-> (cyc_i && stb_i))
    else begin
      $error("ack_o high outside a bus request");
      failCount++;
    end

  ackSingleCycle: assert property (@(posedge ck933) disable iff (clockCounterEn)
    ack_o |=> !ack_o)
    else begin
      $error("ack_o high for two cycles in a row");
      failCount++;
    end

  rstPulseLength: assert property (@(posedge ck933) disable iff (clockCounterEn)
    rstHighCycles <= `RESET_STRETCH)
    else begin
      $error("dacRst_o pulse longer than the stretch length");
      failCount++;
    end

endmodule

bind trellisTop trellisTop_assert trellisTop_assert_i (
  .ck933         (ck933),
  .clockCounterEn(clockCounterEn),
  .cyc_i         (cyc_i),
  .stb_i         (stb_i),
  .ack_o         (ack_o),
  .dacRst_o      (dacRst_o)
);
